// ==== src.f ====
+incdir+test
hdl/stepper_pkg.sv
hdl/motion_if.sv
hdl/spi_byte_rx.sv
hdl/word_assembler.sv
hdl/cmd_decode.sv
hdl/step_execute.sv
hdl/reply_result.sv
hdl/stepper_top.sv
test/tb_stepper_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the stepper testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -f src.f \
  --top-module tb_stepper_top -Mdir obj_dir
./obj_dir/Vtb_stepper_top | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
grep -q "TESTS PASSED" sim.log
echo "Simulation passed"

// ==== test/tb_tasks.svh ====
// Prints the failure and ends the run
task automatic abort_run(input string why);
  $display("%s", why);
  $display("TESTS FAILED");
  $fatal(1, "run stopped at first failure");
endtask

task automatic check_word(input string name, input cmd_word_t got, input cmd_word_t exp);
  if (got !== exp)
    abort_run($sformatf("ERROR at %0t: %s got %h expected %h", $time, name, got, exp));
endtask

task automatic check_phase(input string name, input logic [3:0] got, input logic [3:0] exp);
  if (got !== exp)
    abort_run($sformatf("ERROR at %0t: %s got %b expected %b", $time, name, got, exp));
endtask

task automatic check_count(input string name, input step_count_t got, input step_count_t exp);
  if (got !== exp)
    abort_run($sformatf("ERROR at %0t: %s got %0d expected %0d", $time, name, got, exp));
endtask

task automatic check_gap(input string name, input divisor_t got, input divisor_t exp);
  if (got !== exp)
    abort_run($sformatf("ERROR at %0t: %s got %0d expected %0d", $time, name, got, exp));
endtask

task automatic check_duty(input string name, input logic [3:0] got, input logic [3:0] exp);
  if (got !== exp)
    abort_run($sformatf("ERROR at %0t: %s got %0d expected %0d", $time, name, got, exp));
endtask

function automatic logic [31:0] xorshift();
  rnd_state = rnd_state ^ (rnd_state << 13);
  rnd_state = rnd_state ^ (rnd_state >> 17);
  rnd_state = rnd_state ^ (rnd_state << 5);
  return rnd_state;
endfunction

// Pins {a1, a2, b1, b2} from the signs of cos and sin
function automatic logic [3:0] coil_pattern(input phase_idx_t idx);
  logic [1:0] a;
  logic [1:0] b;
  if (idx == 5'd8 || idx == 5'd24)
    a = 2'b00;
  else if (idx > 5'd8 && idx < 5'd24)
    a = 2'b01;                           // cos negative
  else
    a = 2'b10;
  if (idx == 5'd0 || idx == 5'd16)
    b = 2'b00;
  else if (idx > 5'd16)
    b = 2'b01;                           // sin negative
  else
    b = 2'b10;
  return {a, b};
endfunction

function automatic cmd_word_t status_word(input logic ovr);
  return {OP_STATUS, 6'd0, 1'b0, ovr, exp_count};
endfunction

// Coil pins and PWM duty at rest on a full-step angle
task automatic check_idle_drive();
  logic [3:0] exp_pat;
  logic [3:0] high_a;
  logic [3:0] high_b;
  exp_pat = coil_pattern(exp_idx);
  high_a  = '0;
  high_b  = '0;
  check_phase("coil pins at rest", pat, exp_pat);
  repeat (8) begin                       // One turn of the PWM ramp
    @(posedge word_received);
    high_a = high_a + 4'(pwm_a);
    high_b = high_b + 4'(pwm_b);
  end
  // A driven coil at full magnitude is high 7 of 8 clocks
  check_duty("pwm_a high clocks", high_a, (exp_pat[3:2] == 2'b00) ? 4'd0 : 4'd7);
  check_duty("pwm_b high clocks", high_b, (exp_pat[1:0] == 2'b00) ? 4'd0 : 4'd7);
endtask

// Bytes low first, bits MSB first, MISO read at the end of SCK high
task automatic spi_word(input cmd_word_t tx, output cmd_word_t rx);
  logic [4:0] b;
  @(posedge word_received);
  ssel <= 1'b0;
  repeat (8) @(posedge word_received);
  for (int i = 0; i < 32; i++) begin
    b = 5'(8 * (i / 8) + 7 - (i % 8));
    mosi <= tx[b];
    repeat (4) @(posedge word_received);
    sck <= 1'b1;
    repeat (4) @(posedge word_received);
    rx[b] = miso;
    sck <= 1'b0;
  end
  repeat (4) @(posedge word_received);
  ssel <= 1'b1;
  repeat (8) @(posedge word_received);
endtask

// Status reply comes back during a filler word
task automatic read_status(output cmd_word_t status);
  cmd_word_t unused;
  spi_word({OP_STATUS, 24'd0}, unused);
  spi_word(32'h0, status);
endtask

// Gap before step join_at spans the handover between two moves
task automatic verify_steps(input int n, input divisor_t period, input int join_at);
  int waited;
  waited = 0;
  while (pat_q.size() < n) begin
    @(posedge word_received);
    waited++;
    if (waited > n * 32 + 4000)
      abort_run($sformatf("Timeout waiting for %0d coil changes", n));
  end
  repeat (2 * period + 16) @(posedge word_received);   // Catch extra steps
  check_count("coil change count", step_count_t'(pat_q.size()), step_count_t'(n));
  for (int i = 0; i < n; i++) begin
    exp_idx = exp_idx + step_inc;
    check_phase("coil pins", pat_q[i], coil_pattern(exp_idx));
    if (i > 0 && i != join_at)
      check_gap("step spacing", divisor_t'(time_q[i] - time_q[i - 1]), period);
  end
  exp_count = exp_count + step_count_t'(n);
  pat_q.delete();
  time_q.delete();
endtask

task automatic echo_words(input int n);
  cmd_word_t prev;
  cmd_word_t word;
  cmd_word_t reply;
  prev = '0;                             // Reply after reset
  for (int i = 0; i <= n; i++) begin
    word = xorshift();
    if (word[31:24] >= OP_MOVE && word[31:24] <= OP_USTEP)
      word[31] = 1'b1;                   // Keep the opcode unknown
    spi_word(word, reply);
    check_word("echo reply", reply, prev);
    prev = word;
  end
endtask

task automatic full_step_move();
  cmd_word_t move;
  cmd_word_t reply;
  move = {OP_MOVE, 16'd0, 8'(xorshift() % 12 + 5)};
  spi_word(move, reply);
  verify_steps(int'(move[7:0]), 24'd1, 0);
  spi_word({OP_STATUS, 24'd0}, reply);
  check_word("move echo", reply, move);
  spi_word(32'h0, reply);
  check_word("status after move", reply, status_word(1'b0));
endtask

task automatic divisor_timing();
  cmd_word_t reply;
  divisor_t  d;
  d = divisor_t'(xorshift() % 8 + 2);
  spi_word({OP_DIVISOR, d}, reply);
  spi_word({OP_MOVE, 24'd5}, reply);
  verify_steps(5, d, 0);
  spi_word({OP_DIVISOR, 24'd0}, reply);
  spi_word({OP_MOVE, 24'd4}, reply);
  verify_steps(4, 24'd1, 0);             // Zero acts as one
endtask

task automatic half_step_move();
  cmd_word_t reply;
  spi_word({OP_USTEP, 24'd1}, reply);
  step_inc = 5'd4;
  spi_word({OP_MOVE, 24'd8}, reply);
  verify_steps(8, 24'd1, 0);             // Covers A off at 8 and 24
  spi_word({OP_USTEP, 24'd0}, reply);
  step_inc = 5'd8;
endtask

task automatic back_pressure();
  cmd_word_t reply;
  int        n1;
  int        n2;
  n1 = int'(xorshift() % 8) + 20;
  n2 = int'(xorshift() % 8) + 4;
  spi_word({OP_DIVISOR, 24'd20}, reply);
  spi_word({OP_MOVE, 24'(n1)}, reply);
  spi_word({OP_MOVE, 24'(n2)}, reply);   // Arrives mid move
  verify_steps(n1 + n2, 24'd20, n1);
  read_status(reply);
  check_word("status after queued move", reply, status_word(1'b0));
endtask

task automatic overrun_drop();
  cmd_word_t reply;
  int        n1;
  int        n2;
  n1 = int'(xorshift() % 8) + 60;
  n2 = int'(xorshift() % 8) + 2;
  spi_word({OP_MOVE, 24'(n1)}, reply);
  spi_word({OP_MOVE, 24'(n2)}, reply);   // Pending
  spi_word(32'h0, reply);                // Held
  spi_word(32'h0, reply);                // Lost
  verify_steps(n1 + n2, 24'd20, n1);
  read_status(reply);
  check_word("status with overrun", reply, status_word(1'b1));
  read_status(reply);
  check_word("status after clear", reply, status_word(1'b0));
endtask

// ==== test/tb_stepper_top.sv ====
`timescale 1ns/1ps

module tb_stepper_top;
  import stepper_pkg::*;

  localparam int WORD_CLKS   = 280;    // One framed 32-bit transfer
  localparam int N_WORDS     = 32;
  localparam int MOVE_CLKS   = 2400;   // Longest summed step time of all moves
  localparam int CYCLE_LIMIT = 2 * (N_WORDS * WORD_CLKS + MOVE_CLKS);

  logic word_received = 1'b0;
  logic rst;
  logic sck;
  logic ssel;
  logic mosi;
  logic miso;
  logic phase_a1;
  logic phase_a2;
  logic phase_b1;
  logic phase_b2;
  logic pwm_a;
  logic pwm_b;

  logic [31:0] rnd_state = 32'h900a79ae;
  int          cycle = 0;
  logic [3:0]  pat;
  logic [3:0]  prev_pat;
  logic [3:0]  pat_q[$];      // Coil patterns seen after each change
  int          time_q[$];     // Clock number of each change
  phase_idx_t  exp_idx;       // Expected electrical angle
  phase_idx_t  step_inc;
  step_count_t exp_count;

  stepper_top u_dut (
    .word_received(word_received),
    .rst(rst),
    .sck(sck),
    .ssel(ssel),
    .mosi(mosi),
    .miso(miso),
    .phase_a1(phase_a1),
    .phase_a2(phase_a2),
    .phase_b1(phase_b1),
    .phase_b2(phase_b2),
    .pwm_a(pwm_a),
    .pwm_b(pwm_b)
  );

  `include "tb_tasks.svh"

  always #2 word_received = ~word_received;

  assign pat = {phase_a1, phase_a2, phase_b1, phase_b2};

  // Cycle limit and coil change recorder
  always @(posedge word_received) begin
    cycle <= cycle + 1;
    if (cycle > CYCLE_LIMIT)
      abort_run($sformatf("Timeout: run passed its limit of %0d clocks", CYCLE_LIMIT));
    if (!rst && pat !== prev_pat) begin
      pat_q.push_back(pat);
      time_q.push_back(cycle);
    end
    prev_pat <= pat;
  end

  initial begin
    rst       = 1'b1;
    sck       = 1'b0;
    ssel      = 1'b1;
    mosi      = 1'b0;
    exp_idx   = '0;
    step_inc  = 5'd8;       // Full step after reset
    exp_count = '0;
    repeat (4) @(posedge word_received);
    rst <= 1'b0;
    repeat (4) @(posedge word_received);
    check_idle_drive();
    echo_words(6);
    full_step_move();
    check_idle_drive();
    divisor_timing();
    half_step_move();
    check_idle_drive();
    back_pressure();
    overrun_drop();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== hdl/stepper_top.sv ====
`timescale 1ns/1ps

module stepper_top (
  input  logic word_received,
  input  logic rst,
  input  logic sck,
  input  logic ssel,
  input  logic mosi,
  output logic miso,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2,
  output logic pwm_a,
  output logic pwm_b
);
  import stepper_pkg::*;

  logic      byte_done;
  spi_byte_t rx_byte;
  logic      tx_load;
  spi_byte_t tx_byte;
  logic      word_valid;
  logic      word_ready;
  cmd_word_t word_data;
  logic      overrun;
  logic      accepted;
  cmd_word_t accepted_word;
  logic      overrun_seen;

  motion_if mot ();

  // Host front end
  spi_byte_rx u_spi (
    .word_received, .rst, .sck, .ssel, .mosi,
    .tx_load, .tx_byte, .miso, .byte_done, .rx_byte
  );

  word_assembler u_asm (
    .word_received, .rst, .byte_done, .rx_byte,
    .word_ready, .word_valid, .word_data, .overrun
  );

  cmd_decode u_dec (
    .word_received, .rst, .word_valid, .word_data, .overrun,
    .word_ready, .accepted, .accepted_word, .overrun_seen, .mot(mot.decoder)
  );

  step_execute u_exe (
    .word_received, .rst, .mot(mot.executor),
    .phase_a1, .phase_a2, .phase_b1, .phase_b2, .pwm_a, .pwm_b
  );

  reply_result u_rep (
    .word_received, .rst, .accepted, .accepted_word, .overrun_seen,
    .busy(mot.busy), .step_count(mot.step_count),
    .byte_done, .ssel, .tx_load, .tx_byte
  );

endmodule

// ==== hdl/reply_result.sv ====
`timescale 1ns/1ps

module reply_result (
  input  logic                     word_received,
  input  logic                     rst,
  input  logic                     accepted,
  input  stepper_pkg::cmd_word_t   accepted_word,
  input  logic                     overrun_seen,
  input  logic                     busy,
  input  stepper_pkg::step_count_t step_count,
  input  logic                     byte_done,
  input  logic                     ssel,
  output logic                     tx_load,
  output stepper_pkg::spi_byte_t   tx_byte
);
  import stepper_pkg::*;

  cmd_word_t  reply;
  logic [1:0] byte_idx;
  logic [1:0] ssel_sync;
  logic       ssel_prev;
  logic       ssel_fall;
  logic [1:0] done_pipe;   // Gives the reply time to settle after a word

  assign ssel_fall = ssel_prev & ~ssel_sync[1];

  always_ff @(posedge word_received) begin
    if (rst) begin
      reply     <= '0;
      byte_idx  <= '0;
      ssel_sync <= 2'b11;
      ssel_prev <= 1'b1;
      done_pipe <= '0;
      tx_load   <= 1'b0;
    end else begin
      ssel_sync <= {ssel_sync[0], ssel};
      ssel_prev <= ssel_sync[1];
      done_pipe <= {done_pipe[0], byte_done};
      tx_load   <= ssel_fall | done_pipe[1];
      if (ssel_sync[1])
        byte_idx <= '0;
      else if (byte_done)
        byte_idx <= byte_idx + 2'd1;
      if (accepted) begin
        if (accepted_word[31:24] == OP_STATUS)
          reply <= {accepted_word[31:24], 6'd0, busy, overrun_seen, step_count};
        else
          reply <= accepted_word;   // Echo
      end
    end
  end

  // Low byte first
  always_comb begin
    case (byte_idx)
      2'd0:    tx_byte = reply[7:0];
      2'd1:    tx_byte = reply[15:8];
      2'd2:    tx_byte = reply[23:16];
      default: tx_byte = reply[31:24];
    endcase
  end

endmodule

// ==== hdl/step_execute.sv ====
`timescale 1ns/1ps

module step_execute (
  input  logic       word_received,
  input  logic       rst,
  motion_if.executor mot,
  output logic       phase_a1,
  output logic       phase_a2,
  output logic       phase_b1,
  output logic       phase_b2,
  output logic       pwm_a,
  output logic       pwm_b
);
  import stepper_pkg::*;

  typedef enum logic {S_IDLE, S_STEPPING} state_t;

  state_t     state;
  duration_t  remaining;
  divisor_t   div_cnt;
  divisor_t   div_last;    // Last count of a microstep period
  phase_idx_t phase;
  phase_idx_t phase_inc;
  phase_idx_t cos_idx;     // cos(x) = sin(x + 90 deg)
  logic [2:0] pwm_cnt;
  logic [2:0] mag_a;
  logic [2:0] mag_b;

  // |sin| scaled to 0..7, angle in 1/32 cycle
  function automatic logic [2:0] sin_mag(input phase_idx_t a);
    logic [3:0] m;
    m = a[3] ? 4'(5'd16 - {1'b0, a[3:0]}) : a[3:0];   // Fold to 0..90 deg
    case (m)
      4'd0:       sin_mag = 3'd0;
      4'd1:       sin_mag = 3'd1;
      4'd2:       sin_mag = 3'd3;
      4'd3:       sin_mag = 3'd4;
      4'd4:       sin_mag = 3'd5;
      4'd5, 4'd6: sin_mag = 3'd6;
      default:    sin_mag = 3'd7;
    endcase
  endfunction

  always_comb begin
    case (mot.ustep)
      USTEP_FULL:    phase_inc = 5'd8;
      USTEP_HALF:    phase_inc = 5'd4;
      USTEP_QUARTER: phase_inc = 5'd2;
      USTEP_EIGHTH:  phase_inc = 5'd1;
      default:       phase_inc = 5'd8;
    endcase
  end

  assign div_last = (mot.clk_divisor == '0) ? '0 : mot.clk_divisor - 24'd1;

  always_ff @(posedge word_received) begin
    if (rst) begin
      state          <= S_IDLE;
      remaining      <= '0;
      div_cnt        <= '0;
      phase          <= '0;
      pwm_cnt        <= '0;
      mot.step_count <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 3'd1;     // Free-running PWM ramp
      case (state)
        S_IDLE: begin
          if (mot.move_valid && mot.move_ready) begin
            remaining <= mot.move_duration;
            div_cnt   <= '0;
            state     <= S_STEPPING;
          end
        end
        S_STEPPING: begin
          if (remaining == '0) begin
            state <= S_IDLE;
          end else if (div_cnt >= div_last) begin
            div_cnt        <= '0;
            remaining      <= remaining - 24'd1;
            phase          <= phase + phase_inc;
            mot.step_count <= mot.step_count + 16'd1;
          end else begin
            div_cnt <= div_cnt + 24'd1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  assign mot.busy       = (state == S_STEPPING);
  assign mot.move_ready = (state == S_IDLE);

  // Coil drive, sign from the quadrant and duty from the magnitude
  assign cos_idx  = phase + 5'd8;
  assign mag_a    = sin_mag(cos_idx);
  assign mag_b    = sin_mag(phase);
  assign phase_a1 = (mag_a != 3'd0) & ~cos_idx[4];
  assign phase_a2 = (mag_a != 3'd0) & cos_idx[4];
  assign phase_b1 = (mag_b != 3'd0) & ~phase[4];
  assign phase_b2 = (mag_b != 3'd0) & phase[4];
  assign pwm_a    = (pwm_cnt < mag_a);
  assign pwm_b    = (pwm_cnt < mag_b);

endmodule

// ==== hdl/cmd_decode.sv ====
`timescale 1ns/1ps

module cmd_decode (
  input  logic                   word_received,
  input  logic                   rst,
  input  logic                   word_valid,
  input  stepper_pkg::cmd_word_t word_data,
  input  logic                   overrun,
  output logic                   word_ready,
  output logic                   accepted,
  output stepper_pkg::cmd_word_t accepted_word,
  output logic                   overrun_seen,
  motion_if.decoder              mot
);
  import stepper_pkg::*;

  opcode_t opcode;
  arg_t    arg;
  logic    take;

  assign opcode     = word_data[31:24];
  assign arg        = word_data[23:0];
  assign word_ready = ~mot.move_valid;   // Back-pressure while a move waits
  assign take       = word_valid & word_ready;

  always_ff @(posedge word_received) begin
    if (rst) begin
      accepted        <= 1'b0;
      overrun_seen    <= 1'b0;
      mot.move_valid  <= 1'b0;
      mot.clk_divisor <= DIVISOR_RESET;
      mot.ustep       <= USTEP_RESET;
    end else begin
      accepted <= take;
      if (take) begin
        accepted_word <= word_data;
        case (opcode)
          OP_MOVE: begin
            mot.move_duration <= arg;
            mot.move_valid    <= 1'b1;
          end
          OP_DIVISOR: mot.clk_divisor <= arg;
          OP_USTEP:   mot.ustep       <= arg[1:0];
          default: ;  // Status and unknown words only get a reply
        endcase
      end
      if (mot.move_valid && mot.move_ready)
        mot.move_valid <= 1'b0;
      // Cleared as the status reply samples it
      if (overrun)
        overrun_seen <= 1'b1;
      else if (accepted && accepted_word[31:24] == OP_STATUS)
        overrun_seen <= 1'b0;
    end
  end

endmodule

// ==== hdl/word_assembler.sv ====
`timescale 1ns/1ps

module word_assembler (
  input  logic                   word_received,
  input  logic                   rst,
  input  logic                   byte_done,
  input  stepper_pkg::spi_byte_t rx_byte,
  input  logic                   word_ready,
  output logic                   word_valid,
  output stepper_pkg::cmd_word_t word_data,
  output logic                   overrun
);
  import stepper_pkg::*;

  logic [1:0]  byte_cnt;
  logic [23:0] low_bytes;   // Bytes 0 to 2 while the word builds

  always_ff @(posedge word_received) begin
    if (rst) begin
      byte_cnt   <= '0;
      word_valid <= 1'b0;
      overrun    <= 1'b0;
    end else begin
      overrun <= 1'b0;
      if (word_valid && word_ready)
        word_valid <= 1'b0;
      if (byte_done) begin
        byte_cnt <= byte_cnt + 2'd1;
        case (byte_cnt)
          2'd0: low_bytes[7:0]   <= rx_byte;
          2'd1: low_bytes[15:8]  <= rx_byte;
          2'd2: low_bytes[23:16] <= rx_byte;
          default: begin
            // Still holding an unaccepted word, lose the new one
            if (word_valid && !word_ready) begin
              overrun <= 1'b1;
            end else begin
              word_data  <= {rx_byte, low_bytes};
              word_valid <= 1'b1;
            end
          end
        endcase
      end
    end
  end

endmodule

// ==== hdl/spi_byte_rx.sv ====
`timescale 1ns/1ps

module spi_byte_rx (
  input  logic                  word_received,
  input  logic                  rst,
  input  logic                  sck,
  input  logic                  ssel,
  input  logic                  mosi,
  input  logic                  tx_load,
  input  stepper_pkg::spi_byte_t tx_byte,
  output logic                  miso,
  output logic                  byte_done,
  output stepper_pkg::spi_byte_t rx_byte
);
  import stepper_pkg::*;

  logic [1:0] sck_sync;
  logic [1:0] ssel_sync;
  logic [1:0] mosi_sync;
  logic       sck_prev;
  logic       sck_rise;   // Registered edge pulses
  logic       sck_fall;
  logic       mosi_q;     // Lines up with sck_rise
  logic [2:0] bit_cnt;
  spi_byte_t  rx_shift;
  spi_byte_t  tx_shift;

  // Pin synchronizers and edge detection
  always_ff @(posedge word_received) begin
    sck_sync  <= {sck_sync[0], sck};
    ssel_sync <= {ssel_sync[0], ssel};
    mosi_sync <= {mosi_sync[0], mosi};
    sck_prev  <= sck_sync[1];
    sck_rise  <= sck_sync[1] & ~sck_prev;
    sck_fall  <= ~sck_sync[1] & sck_prev;
    mosi_q    <= mosi_sync[1];
  end

  always_ff @(posedge word_received) begin
    if (rst) begin
      bit_cnt   <= '0;
      byte_done <= 1'b0;
      tx_shift  <= '0;
    end else begin
      byte_done <= 1'b0;
      if (ssel_sync[1]) begin
        bit_cnt <= '0;                             // Deselected
      end else if (sck_rise) begin
        rx_shift  <= {rx_shift[6:0], mosi_q};      // MSB first
        bit_cnt   <= bit_cnt + 3'd1;
        byte_done <= (bit_cnt == 3'd7);
      end
      // Hold the MSB on the fall that starts a new byte
      if (tx_load)
        tx_shift <= tx_byte;
      else if (sck_fall && !ssel_sync[1] && bit_cnt != 3'd0)
        tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

  assign rx_byte = rx_shift;
  assign miso    = tx_shift[7];

endmodule

// ==== hdl/motion_if.sv ====
`timescale 1ns/1ps

interface motion_if;
  import stepper_pkg::*;

  logic        move_valid;
  logic        move_ready;     // Equals not busy
  duration_t   move_duration;
  divisor_t    clk_divisor;
  ustep_t      ustep;
  logic        busy;
  step_count_t step_count;

  modport decoder (output move_valid, move_duration, clk_divisor, ustep,
                   input  move_ready, busy, step_count);

  modport executor (input  move_valid, move_duration, clk_divisor, ustep,
                    output move_ready, busy, step_count);

endinterface

// ==== hdl/stepper_pkg.sv ====
package stepper_pkg;

  // Word and byte widths on the SPI side
  typedef logic [31:0] cmd_word_t;
  typedef logic [7:0]  spi_byte_t;
  typedef logic [7:0]  opcode_t;     // Top byte of a command word
  typedef logic [23:0] arg_t;        // Low three bytes

  // Motion quantities
  typedef logic [23:0] duration_t;   // Microsteps per move
  typedef logic [23:0] divisor_t;    // Clocks per microstep, 0 acts as 1
  typedef logic [1:0]  ustep_t;
  typedef logic [4:0]  phase_idx_t;  // Electrical angle in 1/32 cycle
  typedef logic [15:0] step_count_t; // Wraps at 2^16

  // Opcodes
  localparam opcode_t OP_MOVE    = 8'd1;
  localparam opcode_t OP_STATUS  = 8'd2;
  localparam opcode_t OP_DIVISOR = 8'd3;
  localparam opcode_t OP_USTEP   = 8'd4;

  // Microstep resolution encoding
  localparam ustep_t USTEP_FULL    = 2'd0;
  localparam ustep_t USTEP_HALF    = 2'd1;
  localparam ustep_t USTEP_QUARTER = 2'd2;
  localparam ustep_t USTEP_EIGHTH  = 2'd3;

  // Configuration after reset
  localparam divisor_t DIVISOR_RESET = 24'd1;
  localparam ustep_t   USTEP_RESET   = USTEP_FULL;

endpackage
